// ==== sources.f ====
+incdir+test
verilog/cq_pkg.sv
verilog/rx_meas_pkg.sv
verilog/cq_desc_decoder.sv
verilog/cq_read_requester.sv
verilog/cq_write_packer.sv
verilog/rx_throughput_meter.sv
verilog/cq_rx_engine.sv
test/tb_cq_rx_engine.sv

// ==== Makefile ====
TOP = tb_cq_rx_engine

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard verilog/*.sv) $(wildcard test/*.sv test/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

# pass only when the testbench prints its pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== test/tb_cq_tlp_table.svh ====
// request packet table for the rx engine testbench with the fifo words and request each one gives
`ifndef TB_CQ_TLP_TABLE_SVH
`define TB_CQ_TLP_TABLE_SVH

   localparam int NUM_PKTS = 14;

   // columns are request type, dword count, byte address, tag, requester id, payload seed,
   //          expected fifo words, expected completion request
   // tc and attr of each packet come from tag bits 2:0 and 6:4
   localparam pkt_t PKT_TABLE [NUM_PKTS] = '{
      '{MEM_RD, 11'd1,  32'h0000_0a44, 8'h11, 16'h0100, 32'h0000_0000, 4'd0, 1'b1},
      '{MEM_WR, 11'd1,  32'h0000_0100, 8'h12, 16'h0100, 32'h1000_0000, 4'd1, 1'b0},
      '{MEM_WR, 11'd2,  32'h0000_0200, 8'h13, 16'h0100, 32'h2000_0010, 4'd1, 1'b0},
      '{MEM_WR, 11'd3,  32'h0000_0300, 8'h14, 16'h0200, 32'h3000_0020, 4'd1, 1'b0},
      '{MEM_WR, 11'd4,  32'h0000_0400, 8'h15, 16'h0200, 32'h4000_0030, 4'd1, 1'b0},
      '{MEM_RD, 11'd4,  32'h0000_0500, 8'h26, 16'h0300, 32'h0000_0000, 4'd0, 1'b0},  // dropped
      '{MEM_WR, 11'd5,  32'h0000_0600, 8'h27, 16'h0300, 32'h5000_0040, 4'd1, 1'b0},
      '{MEM_WR, 11'd8,  32'h0000_0700, 8'h38, 16'h0400, 32'h6000_0050, 4'd1, 1'b0},
      '{MEM_RD, 11'd1,  32'h0000_1ffc, 8'hf5, 16'hbeef, 32'h0000_0000, 4'd0, 1'b1},  // top dw
      '{MEM_WR, 11'd12, 32'h0000_0800, 8'h49, 16'h0500, 32'h7000_0060, 4'd2, 1'b0},  // flush
      '{MEM_WR, 11'd17, 32'h0000_0900, 8'h5a, 16'h0500, 32'h8000_0070, 4'd3, 1'b0},  // flush
      '{MEM_RD, 11'd16, 32'h0000_0a00, 8'h6b, 16'h0600, 32'h0000_0000, 4'd0, 1'b0},  // dropped
      '{MEM_WR, 11'd32, 32'h0000_0b00, 8'h7c, 16'h0600, 32'h9000_0080, 4'd4, 1'b0},
      '{MEM_RD, 11'd1,  32'h0000_0004, 8'h0d, 16'h0700, 32'h0000_0000, 4'd0, 1'b1}
   };

`endif

// ==== test/tb_cq_rx_engine.sv ====
// testbench for the completer request rx engine with table packets, reference model and checks
`timescale 1ns/100ps
`default_nettype none

module tb_cq_rx_engine import cq_pkg::*, rx_meas_pkg::*; ();

   localparam int unsigned WIN     = 100;      // short windows
   localparam int unsigned HIST    = 10;
   localparam int unsigned TIMEOUT = 200;      // cycles per wait
   localparam int unsigned N_STB   = 5;        // windows to watch

   // one request packet of the table
   typedef struct packed {
      cq_req_type_e req_type;
      cq_dw_count_t dw_count;
      logic [31:0]  addr;
      logic [7:0]   tag;
      logic [15:0]  req_id;
      logic [31:0]  seed;                      // payload dword i is seed + i
      logic [3:0]   exp_words;
      logic         exp_req;
   } pkt_t;

   `include "tb_cq_tlp_table.svh"

   logic                 clk;
   logic                 rst_n;
   cq_beat_t             cq_beat;
   logic                 cq_tready;
   logic                 compl_done;
   logic                 req_compl;
   rd_req_t              rd_req;
   logic                 fifo_wr_en;
   fifo_word_t           fifo_wr_data;
   logic                 tp_enable;
   logic                 tp_clear;
   logic                 tp_stb;
   tp_count_t [HIST-1:0] tp_hist;

   int unsigned checks   = 0;
   int unsigned errors   = 0;
   int unsigned timeouts = 0;
   int unsigned cyc      = 0;
   fifo_word_t  got_q [$];                     // words seen on the fifo port
   int unsigned stb_q [$];                     // cycle of each tp_stb_o pulse

   cq_rx_engine #(
      .WINDOW_CYCLES (WIN),
      .HIST_DEPTH    (HIST)
   ) i_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .cq_beat_i      (cq_beat),
      .cq_tready_o    (cq_tready),
      .compl_done_i   (compl_done),
      .req_compl_o    (req_compl),
      .rd_req_o       (rd_req),
      .fifo_wr_en_o   (fifo_wr_en),
      .fifo_wr_data_o (fifo_wr_data),
      .tp_enable_i    (tp_enable),
      .tp_clear_i     (tp_clear),
      .tp_stb_o       (tp_stb),
      .tp_hist_o      (tp_hist)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                  // 20 ns period
   end

   always @(posedge clk) cyc <= cyc + 1;

   // registered outputs sampled mid cycle
   always @(negedge clk) begin
      if (rst_n && fifo_wr_en) got_q.push_back(fifo_wr_data);
      if (rst_n && tp_stb) stb_q.push_back(cyc);
   end

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////
   function automatic int unsigned beat_count(input pkt_t p);
      int unsigned cnt;
      cnt = 32'(p.dw_count);
      if (p.req_type != MEM_WR || cnt <= 4) return 1;
      return 1 + (cnt - 4 + 7) / 8;            // dw 0..3 ride in the first beat
   endfunction

   // junk past the count so the zero fill shows
   function automatic logic [31:0] pay_dw(input pkt_t p, input int unsigned idx);
      if (idx < 32'(p.dw_count)) return p.seed + idx;
      return ~(p.seed + idx);
   endfunction

   function automatic cq_beat_t build_beat(input pkt_t p, input int unsigned n);
      cq_beat_t b;
      b       = '0;
      b.valid = 1'b1;
      b.last  = (n == beat_count(p) - 1);
      if (n == 0) begin
         b.data[63:0]    = {32'h0, p.addr};
         b.data[74:64]   = p.dw_count;
         b.data[78:75]   = p.req_type;
         b.data[95:80]   = p.req_id;
         b.data[103:96]  = p.tag;
         b.data[123:121] = p.tag[2:0];         // tc
         b.data[126:124] = p.tag[6:4];         // attr
         b.be            = {(p.dw_count > 11'd1) ? 4'hf : 4'h0, 4'hf};
         if (p.req_type == MEM_WR) begin
            for (int k = 0; k < 4; k++) begin
               b.data[CQ_DESC_W + k*DW_W +: DW_W] = pay_dw(p, k);
            end
         end
      end else begin
         for (int k = 0; k < DW_PER_BEAT; k++) begin
            b.data[k*DW_W +: DW_W] = pay_dw(p, 4 + (n-1)*DW_PER_BEAT + k);
         end
      end
      return b;
   endfunction

   // fifo word w holds dwords 8w..8w+7, zero past the count
   function automatic fifo_word_t expected_word(input pkt_t p, input int unsigned w);
      fifo_word_t  word;
      int unsigned idx;
      word = '0;
      for (int j = 0; j < DW_PER_BEAT; j++) begin
         idx = w * DW_PER_BEAT + j;
         if (idx < 32'(p.dw_count)) word[j*DW_W +: DW_W] = p.seed + idx;
      end
      return word;
   endfunction

   //////////////////////////////////////////////////
   // checks and drivers
   //////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [255:0] got,
                              input logic [255:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_idle();
      check_value("req_compl_o", req_compl, 1'b0);
      check_value("fifo_wr_en_o", fifo_wr_en, 1'b0);
      check_value("tp_stb_o", tp_stb, 1'b0);
      check_value("cq_tready_o", cq_tready, 1'b1);
   endtask

   // called just after a rising edge; holds each beat while ready is low
   task automatic send_packet(input pkt_t p);
      int unsigned waited;
      for (int unsigned n = 0; n < beat_count(p); n++) begin
         cq_beat = build_beat(p, n);
         waited  = 0;
         @(negedge clk);
         while (!cq_tready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
         end
         assert (cq_tready) else begin
            $display("stream stayed not ready for beat %0d at %0t", n, $time);
            errors++;
            timeouts++;
         end
         @(posedge clk);
         #2;
      end
      cq_beat = '0;
   endtask

   task automatic wait_words(input int unsigned n);
      int unsigned waited;
      waited = 0;
      while (got_q.size() < n && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      assert (got_q.size() >= n) else begin
         $display("only %0d of %0d fifo words arrived before the timeout", got_q.size(), n);
         errors++;
         timeouts++;
      end
      repeat (4) @(posedge clk);               // extra words would land here
   endtask

   task automatic compare_words(input pkt_t p);
      for (int unsigned w = 0; w < p.exp_words; w++) begin
         if (got_q.size() > 0) begin
            check_value("fifo_wr_data_o", got_q.pop_front(), expected_word(p, w));
         end
      end
   endtask

   task automatic serve_read(input pkt_t p);
      int unsigned waited;
      int unsigned hold;
      rd_req_t     exp;
      exp = '{addr: p.addr[12:2], len: 10'd1, req_id: p.req_id, tag: p.tag,
              tc: p.tag[2:0], attr: p.tag[6:4], be: 8'h0f};
      waited = 0;
      @(negedge clk);
      while (!req_compl && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      assert (req_compl) else begin
         $display("no completion request for the read with tag %0h", p.tag);
         errors++;
         timeouts++;
      end
      check_value("rd_req_o", rd_req, exp);
      hold = 2 + $urandom % 8;                 // tx side latency
      repeat (hold) begin
         check_value("req_compl_o", req_compl, 1'b1);
         check_value("cq_tready_o", cq_tready, 1'b0);
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      compl_done = 1'b1;
      @(posedge clk);
      #2;
      compl_done = 1'b0;
      @(negedge clk);
      check_value("req_compl_o", req_compl, 1'b0);
      check_value("cq_tready_o", cq_tready, 1'b1);
   endtask

   task automatic watch_dropped_read();
      repeat (8) begin
         @(negedge clk);
         check_value("req_compl_o", req_compl, 1'b0);
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      int unsigned total;
      int unsigned stb_base;
      int unsigned waited;
      tp_count_t   hist_sum;
      void'($urandom(32'heb07_e7ad));
      rst_n      = 1'b0;
      cq_beat    = '0;
      compl_done = 1'b0;
      tp_enable  = 1'b0;
      tp_clear   = 1'b0;
      repeat (15) begin
         @(negedge clk);
         expect_idle();
      end
      @(posedge clk);
      #2;
      rst_n = 1'b1;                            // 16 edges seen in reset
      repeat (2) begin
         @(negedge clk);
         expect_idle();
      end
      @(posedge clk);
      #2;

      for (int i = 0; i < NUM_PKTS; i++) begin
         send_packet(PKT_TABLE[i]);
         if (PKT_TABLE[i].exp_req) begin
            serve_read(PKT_TABLE[i]);
         end else if (PKT_TABLE[i].req_type == MEM_WR) begin
            wait_words(PKT_TABLE[i].exp_words);
         end else begin
            watch_dropped_read();
         end
         check_value("fifo word count", got_q.size(), PKT_TABLE[i].exp_words);
         compare_words(PKT_TABLE[i]);
         got_q.delete();
         @(posedge clk);
         #2;
      end

      // back-to-back writes, then idle windows
      tp_clear  = 1'b1;
      tp_enable = 1'b1;
      @(posedge clk);
      #2;
      tp_clear = 1'b0;
      stb_base = stb_q.size();
      total    = 0;
      for (int i = 0; i < NUM_PKTS; i++) begin
         if (PKT_TABLE[i].req_type == MEM_WR) begin
            send_packet(PKT_TABLE[i]);
            total += PKT_TABLE[i].exp_words;
         end
      end
      wait_words(total);
      check_value("fifo word count", got_q.size(), total);
      for (int i = 0; i < NUM_PKTS; i++) begin
         if (PKT_TABLE[i].req_type == MEM_WR) compare_words(PKT_TABLE[i]);
      end
      waited = 0;
      while (stb_q.size() < stb_base + N_STB && waited < N_STB * WIN + TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      assert (stb_q.size() >= stb_base + N_STB) else begin
         $display("throughput strobes stopped after %0d windows", stb_q.size() - stb_base);
         errors++;
         timeouts++;
      end
      @(negedge clk);
      hist_sum = '0;
      for (int i = 0; i < HIST; i++) hist_sum += tp_hist[i];
      check_value("tp_hist_o sum", hist_sum, total);
      for (int i = stb_base + 1; i < stb_q.size(); i++) begin
         check_value("tp_stb_o spacing", stb_q[i] - stb_q[i-1], WIN);
      end

      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/cq_rx_engine.sv ====
// completer request rx engine top that joins decoder, read requester, write packer and meter
`timescale 1ns/100ps
`default_nettype none

module cq_rx_engine import cq_pkg::*, rx_meas_pkg::*; #(
   parameter int unsigned WINDOW_CYCLES = 25_000_000,  // 100 ms at 250 MHz
   parameter int unsigned HIST_DEPTH    = 10
) (
   input  logic                        clk,
   input  logic                        rst_n,
   // completer request stream
   input  cq_beat_t                    cq_beat_i,
   output logic                        cq_tready_o,
   // completion handshake with tx side
   input  logic                        compl_done_i,
   output logic                        req_compl_o,
   output rd_req_t                     rd_req_o,
   // receive fifo
   output logic                        fifo_wr_en_o,
   output fifo_word_t                  fifo_wr_data_o,
   // throughput meter
   input  logic                        tp_enable_i,
   input  logic                        tp_clear_i,
   output logic                        tp_stb_o,
   output tp_count_t [HIST_DEPTH-1:0]  tp_hist_o
);

   cq_desc_t               desc;
   logic                   desc_stb;
   logic [CQ_DESC_W-1:0]   first_payload;    // dwords 0..3 of a write
   cq_beat_t               cont_beat;
   logic                   rd_busy;          // completion pending
   logic                   flush;            // packer needs an extra cycle

   cq_desc_decoder i_decoder (
      .clk             (clk),
      .rst_n           (rst_n),
      .cq_beat_i       (cq_beat_i),
      .rd_busy_i       (rd_busy),
      .flush_i         (flush),
      .cq_tready_o     (cq_tready_o),
      .desc_o          (desc),
      .desc_stb_o      (desc_stb),
      .first_payload_o (first_payload),
      .cont_beat_o     (cont_beat)
   );

   // beat register still holds the first beat byte enables in the strobe cycle
   cq_read_requester i_rd_req (
      .clk          (clk),
      .rst_n        (rst_n),
      .desc_i       (desc),
      .desc_stb_i   (desc_stb),
      .be_i         (cont_beat.be),
      .compl_done_i (compl_done_i),
      .req_compl_o  (req_compl_o),
      .rd_req_o     (rd_req_o),
      .rd_busy_o    (rd_busy)
   );

   cq_write_packer i_wr_pack (
      .clk             (clk),
      .rst_n           (rst_n),
      .desc_i          (desc),
      .desc_stb_i      (desc_stb),
      .first_payload_i (first_payload),
      .cont_beat_i     (cont_beat),
      .fifo_wr_en_o    (fifo_wr_en_o),
      .fifo_wr_data_o  (fifo_wr_data_o),
      .flush_o         (flush)
   );

   rx_throughput_meter #(
      .WINDOW_CYCLES (WINDOW_CYCLES),
      .HIST_DEPTH    (HIST_DEPTH)
   ) i_meter (
      .clk         (clk),
      .rst_n       (rst_n),
      .word_stb_i  (fifo_wr_en_o),          // one count per fifo word
      .tp_enable_i (tp_enable_i),
      .tp_clear_i  (tp_clear_i),
      .tp_stb_o    (tp_stb_o),
      .tp_hist_o   (tp_hist_o)
   );

endmodule

`default_nettype wire

// ==== verilog/rx_throughput_meter.sv ====
// windowed throughput meter that counts fifo words per window and keeps a count history
`timescale 1ns/100ps
`default_nettype none

module rx_throughput_meter import rx_meas_pkg::*; #(
   parameter int unsigned WINDOW_CYCLES = 25_000_000,
   parameter int unsigned HIST_DEPTH    = 10
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        word_stb_i,     // one fifo word written
   input  logic                        tp_enable_i,
   input  logic                        tp_clear_i,
   output logic                        tp_stb_o,       // history updated
   output tp_count_t [HIST_DEPTH-1:0]  tp_hist_o       // entry 0 is newest
);

   localparam int unsigned WIN_W = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;
   localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(WINDOW_CYCLES - 1);

   logic [WIN_W-1:0] win_cnt_q;
   logic             win_last;     // last cycle of the window
   tp_count_t        word_cnt_q;
   tp_count_t        win_count;    // includes this cycle's write

   assign win_last  = (win_cnt_q == WIN_LAST);
   assign win_count = word_cnt_q + tp_count_t'(word_stb_i);

   // window and word counters
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_cnt_q  <= '0;
         word_cnt_q <= '0;
      end else if (tp_clear_i) begin
         win_cnt_q  <= '0;
         word_cnt_q <= '0;
      end else if (win_last) begin
         win_cnt_q  <= '0;
         word_cnt_q <= '0;                       // restart for the next window
      end else begin
         win_cnt_q  <= win_cnt_q + 1'b1;
         word_cnt_q <= win_count;
      end
   end

   // history shift register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tp_stb_o  <= 1'b0;
         tp_hist_o <= '0;
      end else if (tp_clear_i) begin
         tp_stb_o  <= 1'b0;
         tp_hist_o <= '0;
      end else begin
         tp_stb_o <= win_last && tp_enable_i;
         if (win_last && tp_enable_i) begin
            tp_hist_o[0] <= win_count;
            for (int i = 1; i < HIST_DEPTH; i++) begin
               tp_hist_o[i] <= tp_hist_o[i-1];   // older entries move up
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cq_write_packer.sv ====
// memory write packer that realigns dword-aligned payload into 256-bit fifo words
`timescale 1ns/100ps
`default_nettype none

module cq_write_packer import cq_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  cq_desc_t              desc_i,
   input  logic                  desc_stb_i,
   input  logic [CQ_DESC_W-1:0]  first_payload_i,
   input  cq_beat_t              cont_beat_i,
   output logic                  fifo_wr_en_o,
   output fifo_word_t            fifo_wr_data_o,
   output logic                  flush_o
);

   localparam cq_dw_count_t BEAT_DW = cq_dw_count_t'(DW_PER_BEAT);
   localparam cq_dw_count_t HALF_DW = cq_dw_count_t'(DW_PER_BEAT / 2);

   logic                 wr_start;      // write descriptor strobe
   logic                 short_wr;      // payload fits the first beat
   logic                 beat_in;       // payload beat to pack
   logic                 active_q;
   logic                 flush_pend_q;
   cq_dw_count_t         rem_q;         // dwords left, starting at hold_q
   logic [CQ_DESC_W-1:0] hold_q;        // upper half of previous beat
   fifo_word_t           beat_word;

   // zero every dword at index n and above
   function automatic fifo_word_t mask_dw(input fifo_word_t word, input cq_dw_count_t n);
      fifo_word_t res;
      res = word;
      for (int j = 0; j < DW_PER_BEAT; j++) begin
         if (cq_dw_count_t'(j) >= n) begin
            res[j*DW_W +: DW_W] = '0;
         end
      end
      return res;
   endfunction

   assign wr_start = desc_stb_i && (desc_i.req_type == MEM_WR);
   assign short_wr = (desc_i.dw_count <= HALF_DW);
   assign beat_in  = active_q && cont_beat_i.valid;

   // tlast beat leaves dwords in its upper half
   assign flush_o  = beat_in && cont_beat_i.last && (rem_q > BEAT_DW);

   // new lower half on top of held half
   assign beat_word = mask_dw({cont_beat_i.data[CQ_DESC_W-1:0], hold_q}, rem_q);

   //////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active_q     <= 1'b0;
         flush_pend_q <= 1'b0;
         fifo_wr_en_o <= 1'b0;
      end else begin
         fifo_wr_en_o <= (wr_start && short_wr) || beat_in || flush_pend_q;
         flush_pend_q <= flush_o;
         if (wr_start) begin
            active_q <= !short_wr;                 // short writes finish at once
         end else if (beat_in && (cont_beat_i.last || rem_q <= BEAT_DW)) begin
            active_q <= 1'b0;
         end
      end
   end

   // payload path
   always_ff @(posedge clk) begin
      if (wr_start) begin
         hold_q <= first_payload_i;
         rem_q  <= desc_i.dw_count;
      end else if (beat_in) begin
         hold_q <= cont_beat_i.data[CQ_DATA_W-1 -: CQ_DESC_W];
         rem_q  <= rem_q - BEAT_DW;
      end
      if (flush_pend_q) begin
         fifo_wr_data_o <= mask_dw({{CQ_DESC_W{1'b0}}, hold_q}, rem_q);   // leftover dwords
      end else if (beat_in) begin
         fifo_wr_data_o <= beat_word;
      end else if (wr_start) begin
         fifo_wr_data_o <= mask_dw({{CQ_DESC_W{1'b0}}, first_payload_i}, desc_i.dw_count);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cq_read_requester.sv ====
// single dword memory read requester that holds the completion request until tx is done
`timescale 1ns/100ps
`default_nettype none

module cq_read_requester import cq_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   input  cq_desc_t               desc_i,
   input  logic                   desc_stb_i,
   input  logic [DW_PER_BEAT-1:0] be_i,
   input  logic                   compl_done_i,
   output logic                   req_compl_o,
   output rd_req_t                rd_req_o,
   output logic                   rd_busy_o
);

   logic rd_hit;   // new 1 dw read in this cycle

   // longer reads are dropped here
   assign rd_hit = desc_stb_i
                   && (desc_i.req_type == MEM_RD)
                   && (desc_i.dw_count == cq_dw_count_t'(1));

   // strobe cycle counts as busy so no beat slips in behind the read
   assign rd_busy_o = req_compl_o | rd_hit;

   // pending/done wait
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_compl_o <= 1'b0;
      end else if (rd_hit) begin
         req_compl_o <= 1'b1;
      end else if (compl_done_i) begin
         req_compl_o <= 1'b0;           // low the cycle after done
      end
   end

   // request fields, stable while req_compl_o is high
   always_ff @(posedge clk) begin
      if (rd_hit) begin
         rd_req_o.addr   <= desc_i.dw_addr;
         rd_req_o.len    <= desc_i.dw_count[9:0];
         rd_req_o.req_id <= desc_i.req_id;
         rd_req_o.tag    <= desc_i.tag;
         rd_req_o.tc     <= desc_i.tc;
         rd_req_o.attr   <= desc_i.attr;
         rd_req_o.be     <= be_i;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cq_desc_decoder.sv ====
// completer request decoder with packet tracking, descriptor decode and stream ready
`timescale 1ns/100ps
`default_nettype none

module cq_desc_decoder import cq_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  cq_beat_t              cq_beat_i,
   input  logic                  rd_busy_i,        // completion request pending
   input  logic                  flush_i,          // packer flush cycle
   output logic                  cq_tready_o,
   output cq_desc_t              desc_o,
   output logic                  desc_stb_o,
   output logic [CQ_DESC_W-1:0]  first_payload_o,
   output cq_beat_t              cont_beat_o
);

   logic     beat_acc;     // valid and ready
   logic     sop;          // accepted first beat
   logic     in_pkt_q;     // between first beat and tlast
   logic     wr_pkt_q;     // current packet is a memory write
   logic     cont_vld_q;
   cq_beat_t beat_q;       // last accepted beat
   cq_desc_t desc_q;

   // field positions of the dword-aligned cq descriptor
   function automatic cq_desc_t decode_desc(input logic [CQ_DESC_W-1:0] d);
      cq_desc_t r;
      r.dw_addr  = d[12:2];
      r.dw_count = d[74:64];
      r.req_type = cq_req_type_e'(d[78:75]);
      r.req_id   = d[95:80];
      r.tag      = d[103:96];
      r.tc       = d[123:121];
      r.attr     = d[126:124];
      return r;
   endfunction

   // hold off while a completion is pending or the packer flushes
   assign cq_tready_o = ~(rd_busy_i | flush_i);

   assign beat_acc = cq_beat_i.valid & cq_tready_o;
   assign sop      = beat_acc & ~in_pkt_q;

   //////////////////////////////////////////////////
   // packet tracking
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q   <= 1'b0;
         wr_pkt_q   <= 1'b0;
         desc_stb_o <= 1'b0;
         cont_vld_q <= 1'b0;
      end else begin
         if (beat_acc && cq_beat_i.last) begin
            in_pkt_q <= 1'b0;                     // single beat packets never set it
         end else if (sop) begin
            in_pkt_q <= 1'b1;
         end
         if (sop) begin
            wr_pkt_q <= (cq_beat_i.data[78:75] == MEM_WR);
         end
         desc_stb_o <= sop;
         cont_vld_q <= beat_acc & in_pkt_q & wr_pkt_q;   // write payload beats only
      end
   end

   // descriptor and beat registers
   always_ff @(posedge clk) begin
      if (sop) begin
         desc_q <= decode_desc(cq_beat_i.data[CQ_DESC_W-1:0]);
      end
      if (beat_acc) begin
         beat_q <= cq_beat_i;
      end
   end

   assign desc_o          = desc_q;
   assign first_payload_o = beat_q.data[CQ_DATA_W-1 -: CQ_DESC_W];   // upper half, dw 0..3

   // continuation beat one cycle late, valid only for write payload
   always_comb begin
      cont_beat_o       = beat_q;
      cont_beat_o.valid = cont_vld_q;
   end

endmodule

`default_nettype wire

// ==== verilog/rx_meas_pkg.sv ====
// throughput measurement package with the word count type of the meter history
`default_nettype none

package rx_meas_pkg;

   //////////////////////////////////////////////////
   // throughput counting
   //////////////////////////////////////////////////

   // wide enough for any window at 250 MHz
   localparam int TP_COUNT_W = 32;

   // fifo words seen in one window
   typedef logic [TP_COUNT_W-1:0] tp_count_t;

endpackage

`default_nettype wire

// ==== verilog/cq_pkg.sv ====
// completer request package with stream beat, descriptor, read request and fifo word types
`default_nettype none

package cq_pkg;

   //////////////////////////////////////////////////
   // stream geometry
   //////////////////////////////////////////////////
   localparam int CQ_DATA_W   = 256;                 // cq tdata width
   localparam int CQ_DESC_W   = 128;                 // descriptor, also half a beat
   localparam int DW_W        = 32;
   localparam int DW_PER_BEAT = CQ_DATA_W / DW_W;    // 8 dwords per beat

   typedef logic [10:0] cq_dw_count_t;               // dword count field of the descriptor

   // request type field, descriptor bits 78:75
   typedef enum logic [3:0] {
      MEM_RD = 4'd0,
      MEM_WR = 4'd1
   } cq_req_type_e;

   // one beat of the completer request stream
   typedef struct packed {
      logic [CQ_DATA_W-1:0]   data;
      logic [DW_PER_BEAT-1:0] be;                    // first/last dword byte enables
      logic                   valid;
      logic                   last;
   } cq_beat_t;

   // decoded fields of the first beat
   typedef struct packed {
      logic [10:0]  dw_addr;                         // address bits 12:2
      cq_dw_count_t dw_count;
      cq_req_type_e req_type;
      logic [15:0]  req_id;
      logic [7:0]   tag;
      logic [2:0]   tc;
      logic [2:0]   attr;
   } cq_desc_t;

   // completion request toward the tx side
   typedef struct packed {
      logic [10:0] addr;
      logic [9:0]  len;
      logic [15:0] req_id;
      logic [7:0]  tag;
      logic [2:0]  tc;
      logic [2:0]  attr;
      logic [7:0]  be;
   } rd_req_t;

   typedef logic [CQ_DATA_W-1:0] fifo_word_t;        // payload dword j at bits 32j and up

endpackage

`default_nettype wire
